//--- src/seq_pkg.sv
package seq_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////
	localparam int COND_W = 12; // Flags x1..x12
	localparam int OPS_W = 20; // Strobes y1..y20
	localparam int CMD_W = 14; // Opcode on top of the flags

	typedef enum logic [4:0]
	{
		S1 = 5'd1, S2 = 5'd2, S3 = 5'd3, S4 = 5'd4, S5 = 5'd5, S6 = 5'd6,
		S7 = 5'd7, S8 = 5'd8, S9 = 5'd9, S10 = 5'd10, S11 = 5'd11,
		S12 = 5'd12, S13 = 5'd13, S14 = 5'd14, S15 = 5'd15, S16 = 5'd16,
		S17 = 5'd17
	} seq_state_e;

	typedef enum logic [1:0]
	{
		OP_STEP = 2'd0,
		OP_RESTART = 2'd1,
		OP_RSVD2 = 2'd2, // Acts as restart
		OP_RSVD3 = 2'd3 // Acts as restart
	} seq_op_e;

	//////////////////////////////
	// AXI4-Lite
	//////////////////////////////
	localparam logic [3:0] ADDR_CMD = 4'h0;
	localparam logic [3:0] ADDR_STATUS = 4'h4;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- src/axil_cmd_writer.sv
`timescale 1ns/100ps
module axil_cmd_writer #(
	parameter int FIFO_DEPTH = 4
) (
	input logic rst,
	input logic clk,
	input logic [3:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [3:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic push,
	output logic [seq_pkg::CMD_W-1:0] push_data,
	input logic full,
	input logic [$clog2(FIFO_DEPTH+1)-1:0] count,
	input seq_pkg::seq_state_e cur_state
);
	import seq_pkg::*;

	logic [3:0] count4;

	assign count4 = 4'(count);
	assign push = awready && (awaddr == ADDR_CMD) && !full; // Dropped when full
	assign push_data = wdata[CMD_W-1:0];

	//////////////////////////////
	// Write channel
	//////////////////////////////
	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
		end
		else
		begin
			awready <= awvalid && wvalid && !bvalid && !awready;
			wready <= awvalid && wvalid && !bvalid && !awready;
			if (awready)
			begin
				bvalid <= 1'b1;
				bresp <= push ? RESP_OKAY : RESP_SLVERR;
			end
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	//////////////////////////////
	// Read channel
	//////////////////////////////
	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			arready <= arvalid && !rvalid && !arready;
			if (arready)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge rst)
	begin
		if (arready)
		begin
			rdata <= (araddr == ADDR_STATUS) ? 32'({count4, 3'b000, cur_state}) : 32'd0;
			rresp <= (araddr == ADDR_STATUS) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	a_bvalid_hold: assert property (@(posedge rst) disable iff (!clk)
		bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

//--- src/cmd_fifo.sv
`timescale 1ns/100ps
module cmd_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input logic rst,
	input logic clk,
	input logic push,
	input logic [seq_pkg::CMD_W-1:0] push_data,
	input logic pop,
	output logic [seq_pkg::CMD_W-1:0] pop_data,
	output logic full,
	output logic empty,
	output logic [$clog2(FIFO_DEPTH+1)-1:0] count
);
	import seq_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	logic [CMD_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign full = (count == FIFO_DEPTH);
	assign empty = (count == 0);
	assign pop_data = mem[rd_ptr];
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	always_ff @(posedge rst)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	a_no_overflow: assert property (@(posedge rst) disable iff (!clk) !(push && full));
	a_no_underflow: assert property (@(posedge rst) disable iff (!clk) !(pop && empty));

endmodule

//--- src/micro_sequencer.sv
`timescale 1ns/100ps
module micro_sequencer (
	input logic rst,
	input logic clk,
	input logic empty,
	output logic pop,
	input logic [seq_pkg::CMD_W-1:0] pop_data,
	output logic step_valid,
	output logic [seq_pkg::OPS_W-1:0] step_ops,
	output seq_pkg::seq_state_e step_state,
	output seq_pkg::seq_state_e cur_state
);
	import seq_pkg::*;

	// Strobe groups, yk at bit k-1
	localparam logic [OPS_W-1:0] Y0 = '0;
	localparam logic [OPS_W-1:0] Y4 = OPS_W'(1) << 3;
	localparam logic [OPS_W-1:0] Y5 = OPS_W'(1) << 4;
	localparam logic [OPS_W-1:0] Y6 = OPS_W'(1) << 5;
	localparam logic [OPS_W-1:0] Y13 = OPS_W'(1) << 12;
	localparam logic [OPS_W-1:0] Y16 = OPS_W'(1) << 15;
	localparam logic [OPS_W-1:0] Y18 = OPS_W'(1) << 17;
	localparam logic [OPS_W-1:0] Y19 = OPS_W'(1) << 18;
	localparam logic [OPS_W-1:0] Y20 = OPS_W'(1) << 19;
	localparam logic [OPS_W-1:0] Y1_2_3 = OPS_W'(20'b111);
	localparam logic [OPS_W-1:0] Y1_8_9 = OPS_W'(20'b1_1000_0001);
	localparam logic [OPS_W-1:0] Y1_2_12 = OPS_W'(20'b1000_0000_0011);
	localparam logic [OPS_W-1:0] Y1_11_12 = OPS_W'(20'b1100_0000_0001);
	localparam logic [OPS_W-1:0] Y2_10_12 = OPS_W'(20'b1010_0000_0010);
	localparam logic [OPS_W-1:0] Y10_11_12 = OPS_W'(20'b1110_0000_0000);
	localparam logic [OPS_W-1:0] Y7_9_15 = OPS_W'(20'b100_0001_0100_0000);
	localparam logic [OPS_W-1:0] Y8_9_17 = OPS_W'(20'b1_0000_0001_1000_0000);
	localparam logic [OPS_W-1:0] Y1_9_14_15 = OPS_W'(20'b110_0001_0000_0001);

	seq_state_e state;
	seq_state_e nx_state;
	seq_op_e op;
	logic [COND_W:1] x; // x[k] is flag xk
	logic [OPS_W-1:0] nx_ops;
	logic [4+OPS_W:0] t; // {next state, strobes}

	assign pop = !empty;
	assign cur_state = state;
	assign x = pop_data[COND_W-1:0];
	assign op = seq_op_e'(pop_data[CMD_W-1:COND_W]);
	assign nx_state = seq_state_e'(t[4+OPS_W:OPS_W]);
	assign nx_ops = t[OPS_W-1:0];

	//////////////////////////////
	// Transition table
	//////////////////////////////
	always_comb
	begin
		t = {S1, Y0};
		if (op == OP_STEP)
		begin
			case (state)
				S1:
					if (x[12])
						if (x[10])
							t = x[11] ? {S2, Y18} : {S3, Y2_10_12};
						else if (x[11])
							t = {S4, Y10_11_12};
						else if (x[1])
							t = {S5, Y1_2_3};
						else
							t = x[2] ? {S6, Y5} : {S7, Y4};
					else if (x[9])
						if (!x[11] && x[7])
							t = {S10, Y16};
						else if (x[1])
							t = x[5] ? {S8, Y19} : {S9, Y1_8_9};
						else
							t = {S5, Y1_2_3};
					else if (x[10])
						if (x[11] && x[8])
							t = {S10, Y16};
						else if (x[11])
							t = x[5] ? {S8, Y19} : {S9, Y1_8_9};
						else
							t = x[5] ? {S11, Y1_2_12} : {S9, Y1_8_9};
					else if (!x[1])
						t = {S5, Y1_2_3};
					else if (x[11])
						t = (x[3] && x[6]) ? {S12, Y7_9_15} : {S9, Y1_8_9};
					else
						t = x[5] ? {S3, Y2_10_12} : {S9, Y1_8_9};
				S2:
					if (x[12])
						t = x[1] ? {S12, Y7_9_15} : {S13, Y20};
					else
						t = {S1, Y0};
				S3, S4:
					if (x[12] && state == S3)
						t = {S14, Y13};
					else if (x[12])
						if (x[1])
							t = {S5, Y1_2_3};
						else
							t = x[2] ? {S6, Y5} : {S7, Y4};
					else if (x[2])
						t = x[6] ? {S15, Y1_9_14_15} : {S14, Y13};
					else
						t = {state, Y0};
				S5:
					if (x[12])
						t = x[2] ? {S6, Y5} : {S7, Y4};
					else
						t = x[2] ? {S7, Y4} : {S5, Y0};
				S6, S7:
					if (x[12] && x[10] && state == S6)
						t = (x[8] && !x[1]) ? {S9, Y1_8_9} : {S8, Y19};
					else if (x[12] && x[10])
						t = x[11] ? {S8, Y19} : {S15, Y1_9_14_15};
					else if (x[12] && x[1])
						t = {S5, Y1_2_3};
					else if (x[12])
						t = x[3] ? {S1, Y0} : {S9, Y1_8_9};
					else if (x[9])
						t = x[5] ? {S8, Y19} : {S9, Y1_8_9};
					else if (x[10] && state == S6)
						if (x[5])
							t = x[11] ? {S8, Y19} : {S11, Y1_2_12};
						else
							t = {S9, Y1_8_9};
					else if (x[11])
						t = (x[3] && x[6]) ? {S12, Y7_9_15} : {S9, Y1_8_9};
					else
						t = x[5] ? {S3, Y2_10_12} : {S9, Y1_8_9};
				S8:
					if (!x[12])
						t = {S17, Y8_9_17};
					else if (x[5])
						t = {S16, Y6};
					else
						t = x[1] ? {S7, Y4} : {S6, Y5};
				S9:
					if (x[12])
						t = {S1, Y0};
					else if (!x[4])
						t = {S9, Y0};
					else if (!x[9] && x[10] && !x[11] && x[3])
						t = {S11, Y1_11_12};
					else if (!x[9] && !x[10] && x[3])
						t = x[11] ? {S13, Y20} : {S4, Y10_11_12};
					else
						t = {S6, Y5};
				S10: t = (x[12] && x[7]) ? {S1, Y0} : {S17, Y8_9_17};
				S11: t = x[2] ? {S16, Y6} : {S11, Y0};
				S12:
					if (x[12])
						t = {S13, Y20};
					else
						t = x[4] ? {S10, Y16} : {S12, Y0};
				S13:
					if (x[12])
						t = x[1] ? {S7, Y4} : {S6, Y5};
					else
						t = {S10, Y16};
				S14:
					if (x[12])
						t = x[4] ? {S7, Y4} : {S15, Y1_9_14_15};
					else
						t = {S10, Y16};
				S15:
					if (x[12] && x[5] && x[6])
						t = {S10, Y16};
					else if (x[12] && x[5])
						t = x[7] ? {S1, Y0} : {S17, Y8_9_17};
					else if (x[12])
						t = x[4] ? {S7, Y4} : {S15, Y1_9_14_15};
					else
						t = x[4] ? {S10, Y16} : {S15, Y0};
				S16:
					if (!x[12] || x[9])
						t = {S10, Y16};
					else
						t = x[7] ? {S1, Y0} : {S17, Y8_9_17};
				S17:
					if (x[12])
						t = {S1, Y0};
					else
						t = x[4] ? {S2, Y18} : {S17, Y0};
				default: t = {S1, Y0}; // Recover from an illegal code
			endcase
		end
	end

	//////////////////////////////
	// State and step registers
	//////////////////////////////
	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			state <= S1;
			step_valid <= 1'b0;
			step_ops <= '0;
			step_state <= S1;
		end
		else
		begin
			step_valid <= pop; // One pulse per command
			if (pop)
			begin
				state <= nx_state;
				step_ops <= nx_ops;
				step_state <= nx_state;
			end
		end
	end

	a_legal_state: assert property (@(posedge rst) disable iff (!clk)
		state inside {[S1:S17]});

endmodule

//--- src/seq_top.sv
`timescale 1ns/100ps
module seq_top #(
	parameter int FIFO_DEPTH = 4
) (
	input logic rst,
	input logic clk,
	input logic [3:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [3:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic step_valid,
	output logic [seq_pkg::OPS_W-1:0] step_ops,
	output seq_pkg::seq_state_e step_state
);
	import seq_pkg::*;

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic push;
	logic pop;
	logic full;
	logic empty;
	logic [CMD_W-1:0] push_data;
	logic [CMD_W-1:0] pop_data;
	logic [CNT_W-1:0] count;
	seq_state_e cur_state;

	axil_cmd_writer #(.FIFO_DEPTH(FIFO_DEPTH)) u_axil_cmd_writer (
		.rst(rst), .clk(clk),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.push(push), .push_data(push_data), .full(full), .count(count),
		.cur_state(cur_state)
	);

	cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_cmd_fifo (
		.rst(rst), .clk(clk),
		.push(push), .push_data(push_data),
		.pop(pop), .pop_data(pop_data),
		.full(full), .empty(empty), .count(count)
	);

	micro_sequencer u_micro_sequencer (
		.rst(rst), .clk(clk),
		.empty(empty), .pop(pop), .pop_data(pop_data),
		.step_valid(step_valid), .step_ops(step_ops),
		.step_state(step_state), .cur_state(cur_state)
	);

endmodule

//--- tests/tb_seq_top.sv
`timescale 1ns/100ps
module tb_seq_top;
	import seq_pkg::*;

	localparam int FIFO_DEPTH = 4;
	localparam int TIMEOUT = 50; // Cycles allowed per wait
	localparam int BURST_N = FIFO_DEPTH + 4;

	logic rst; // Clock
	logic clk; // Reset, active low
	logic [3:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [3:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic step_valid;
	logic [OPS_W-1:0] step_ops;
	seq_state_e step_state;

	integer seed;
	logic [24:0] obs_q [$]; // {state, strobes} per step pulse

	seq_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_seq_top (
		.rst(rst), .clk(clk),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.step_valid(step_valid), .step_ops(step_ops), .step_state(step_state)
	);

	always #20 rst = ~rst;

	always @(negedge rst)
	begin
		if (clk && step_valid)
			obs_q.push_back({step_state, step_ops});
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////
	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string name);
		if (actual !== expected)
		begin
			$display("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual,
				expected);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("ERROR at %0t ns: %s never came", $time, what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	function automatic logic [31:0] onehot(input int k);
		return 32'd1 << (k - 1); // Flag xk or strobe yk
	endfunction

	function automatic logic [CMD_W-1:0] build_cmd(input seq_op_e op,
		input logic [31:0] set, input logic [31:0] clr);
		logic [31:0] f;
		f = $random(seed); // Flags the row ignores
		f = (f & ~clr) | set;
		return {op, f[COND_W-1:0]};
	endfunction

	// Next command of the walk S1, S2, S12, S13, S10, S17, S1
	task automatic path_step(input seq_state_e from, output logic [CMD_W-1:0] cmd,
		output seq_state_e nx, output logic [31:0] ops);
		cmd = build_cmd(OP_RESTART, 0, 0);
		nx = S1;
		ops = 0;
		case (from)
			S1:
			begin
				cmd = build_cmd(OP_STEP, onehot(12) | onehot(10) | onehot(11), 0);
				nx = S2;
				ops = onehot(18);
			end
			S2:
			begin
				cmd = build_cmd(OP_STEP, onehot(12) | onehot(1), 0);
				nx = S12;
				ops = onehot(7) | onehot(9) | onehot(15);
			end
			S12:
			begin
				cmd = build_cmd(OP_STEP, onehot(12), 0);
				nx = S13;
				ops = onehot(20);
			end
			S13:
			begin
				cmd = build_cmd(OP_STEP, 0, onehot(12));
				nx = S10;
				ops = onehot(16);
			end
			S10:
			begin
				cmd = build_cmd(OP_STEP, 0, onehot(12));
				nx = S17;
				ops = onehot(8) | onehot(9) | onehot(17);
			end
			S17:
			begin
				cmd = build_cmd(OP_STEP, onehot(12), 0);
				nx = S1;
			end
			default: ;
		endcase
	endtask

	//////////////////////////////
	// Bus tasks
	//////////////////////////////
	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data, input int hold,
		output logic [1:0] resp);
		int n;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = (hold == 0);
		n = 0;
		@(negedge rst);
		while (!awready)
		begin
			if (n == TIMEOUT)
				report_timeout("awready");
			n++;
			@(negedge rst);
		end
		check(wready, 1, "wready");
		@(negedge rst); // Address and data taken at this edge
		awvalid = 1'b0;
		wvalid = 1'b0;
		n = 0;
		while (!bvalid)
		begin
			if (n == TIMEOUT)
				report_timeout("bvalid");
			n++;
			@(negedge rst);
		end
		resp = bresp;
		for (n = 0; n < hold; n++)
		begin
			check(bvalid, 1, "bvalid");
			check(bresp, resp, "bresp");
			@(negedge rst);
		end
		check(bvalid, 1, "bvalid");
		bready = 1'b1;
		@(negedge rst);
		check(bvalid, 0, "bvalid");
		bready = 1'b0;
	endtask

	task automatic axil_read(input logic [3:0] addr, input int hold, output logic [31:0] data,
		output logic [1:0] resp);
		int n;
		araddr = addr;
		arvalid = 1'b1;
		rready = (hold == 0);
		n = 0;
		@(negedge rst);
		while (!arready)
		begin
			if (n == TIMEOUT)
				report_timeout("arready");
			n++;
			@(negedge rst);
		end
		@(negedge rst);
		arvalid = 1'b0;
		n = 0;
		while (!rvalid)
		begin
			if (n == TIMEOUT)
				report_timeout("rvalid");
			n++;
			@(negedge rst);
		end
		data = rdata;
		resp = rresp;
		for (n = 0; n < hold; n++)
		begin
			check(rvalid, 1, "rvalid");
			check(rdata, data, "rdata");
			check(rresp, resp, "rresp");
			@(negedge rst);
		end
		check(rvalid, 1, "rvalid");
		rready = 1'b1;
		@(negedge rst);
		check(rvalid, 0, "rvalid");
		rready = 1'b0;
	endtask

	task automatic wait_step(output logic [4:0] st, output logic [OPS_W-1:0] ops);
		int n;
		logic [24:0] item;
		n = 0;
		while (obs_q.size() == 0)
		begin
			if (n == TIMEOUT)
				report_timeout("step_valid");
			n++;
			@(posedge rst);
		end
		item = obs_q.pop_front();
		st = item[24:20];
		ops = item[19:0];
		@(negedge rst);
	endtask

	task automatic send_expect(input logic [CMD_W-1:0] cmd, input seq_state_e exp_state,
		input logic [31:0] exp_ops);
		logic [1:0] resp;
		logic [4:0] st;
		logic [OPS_W-1:0] ops;
		axil_write(ADDR_CMD, 32'(cmd), 0, resp);
		check(resp, RESP_OKAY, "bresp");
		wait_step(st, ops);
		check(st, exp_state, "step_state");
		check(ops, exp_ops, "step_ops");
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////
	task automatic test_reset_status();
		logic [31:0] data;
		logic [1:0] resp;
		axil_read(ADDR_STATUS, 0, data, resp);
		check(resp, RESP_OKAY, "rresp");
		check(data, 32'h0000_0001, "rdata"); // S1 with an empty FIFO
		check(step_valid, 0, "step_valid");
		check(obs_q.size(), 0, "step pulses");
	endtask

	task automatic test_path_walk();
		seq_state_e st;
		seq_state_e nx;
		logic [CMD_W-1:0] cmd;
		logic [31:0] ops;
		logic [31:0] data;
		logic [1:0] resp;
		st = S1;
		repeat (6)
		begin
			path_step(st, cmd, nx, ops);
			send_expect(cmd, nx, ops);
			st = nx;
		end
		axil_read(ADDR_STATUS, 0, data, resp);
		check(resp, RESP_OKAY, "rresp");
		check(data, 32'h0000_0001, "rdata");
	endtask

	task automatic test_hold_and_restart();
		logic [31:0] data;
		logic [1:0] resp;
		send_expect(build_cmd(OP_STEP, onehot(12) | onehot(10) | onehot(11), 0), S2, onehot(18));
		send_expect(build_cmd(OP_STEP, onehot(12), onehot(1)), S13, onehot(20));
		send_expect(build_cmd(OP_STEP, 0, onehot(12)), S10, onehot(16));
		send_expect(build_cmd(OP_STEP, 0, onehot(12)), S17, onehot(8) | onehot(9) | onehot(17));
		send_expect(build_cmd(OP_STEP, 0, onehot(12) | onehot(4)), S17, 0); // Hold
		axil_read(ADDR_STATUS, 0, data, resp);
		check(resp, RESP_OKAY, "rresp");
		check(data, 32'h0000_0011, "rdata");
		send_expect(build_cmd(OP_RESTART, 0, 0), S1, 0);
	endtask

	task automatic test_full_fifo();
		int okay_n;
		int i;
		logic [1:0] resp;
		logic [CMD_W-1:0] cmd;
		seq_state_e cur;
		seq_state_e nx;
		logic [31:0] ops;
		logic [4:0] st;
		logic [OPS_W-1:0] got_ops;
		seq_state_e exp_state_q [$];
		logic [31:0] exp_ops_q [$];
		cur = S1;
		okay_n = 0;
		for (i = 0; i < BURST_N; i++)
		begin
			path_step(cur, cmd, nx, ops);
			axil_write(ADDR_CMD, 32'(cmd), 0, resp);
			if (resp == RESP_OKAY)
			begin
				okay_n++;
				exp_state_q.push_back(nx);
				exp_ops_q.push_back(ops);
				cur = nx; // Dropped commands leave the walk where it was
			end
			else
				check(resp, RESP_SLVERR, "bresp");
		end
		for (i = 0; i < okay_n; i++)
		begin
			wait_step(st, got_ops);
			check(st, exp_state_q.pop_front(), "step_state");
			check(got_ops, exp_ops_q.pop_front(), "step_ops");
		end
		repeat (4) @(posedge rst);
		check(obs_q.size(), 0, "step pulses");
		@(negedge rst);
		axil_write(4'h8, 32'h0, 0, resp);
		check(resp, RESP_SLVERR, "bresp");
		repeat (4) @(posedge rst);
		check(obs_q.size(), 0, "step pulses");
		@(negedge rst);
	endtask

	task automatic test_back_pressure();
		int k;
		logic [1:0] resp;
		logic [31:0] data;
		logic [4:0] st;
		logic [OPS_W-1:0] ops;
		for (k = 0; k < 3; k++)
		begin
			axil_write(ADDR_CMD, 32'(build_cmd(k == 2 ? OP_RSVD2 : OP_RESTART, 0, 0)),
				1 + ({$random(seed)} % 8), resp);
			check(resp, RESP_OKAY, "bresp");
			wait_step(st, ops);
			check(st, S1, "step_state");
			check(ops, 0, "step_ops");
			axil_write(4'hC, 32'h0, 1 + ({$random(seed)} % 8), resp);
			check(resp, RESP_SLVERR, "bresp");
			axil_read(ADDR_STATUS, 1 + ({$random(seed)} % 8), data, resp);
			check(resp, RESP_OKAY, "rresp");
			check(data, 32'h0000_0001, "rdata");
			axil_read(4'h8, 1 + ({$random(seed)} % 8), data, resp);
			check(resp, RESP_SLVERR, "rresp");
			check(data, 32'h0, "rdata");
		end
	endtask

	initial
	begin
		seed = 32'h1676;
		rst = 1'b0;
		clk = 1'b0;
		awaddr = 4'h0;
		awvalid = 1'b0;
		wdata = 32'h0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = 4'h0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (4) @(negedge rst);
		clk = 1'b1; // Release reset
		@(negedge rst);
		test_reset_status();
		test_path_walk();
		test_hold_and_restart();
		test_full_fifo();
		test_back_pressure();
		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- verilog.f
src/seq_pkg.sv
src/axil_cmd_writer.sv
src/cmd_fifo.sv
src/micro_sequencer.sv
src/seq_top.sv
tests/tb_seq_top.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_seq_top
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
